// File: source/isa_pkg.sv
package isa_pkg;

  // Datapath width
  localparam int XLEN = 32;

  // Architectural register file
  localparam int NREG = 32;
  // 5-bit register addresses
  localparam int REG_AW = $clog2(NREG);

  // Instruction word layout, opcode in the top nibble
  localparam int OPC_HI = 31;
  localparam int OPC_LO = 28;

  // Destination register
  localparam int RD_HI = 27;
  localparam int RD_LO = 23;

  // First source register
  localparam int RS1_HI = 22;
  localparam int RS1_LO = 18;

  // Second source register
  localparam int RS2_HI = 17;
  localparam int RS2_LO = 13;

  // Signed immediate, sign bit at IMM_HI
  localparam int IMM_HI = 12;
  localparam int IMM_LO = 0;
  localparam int IMM_W = IMM_HI - IMM_LO + 1;

  // Opcode encodings
  // Codes above OP_MUL decode as OP_NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_SLT  = 4'h6,
    OP_ADDI = 4'h7,
    OP_MUL  = 4'h8
  } opcode_e;

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

  // Issue to execute
  // Operand values are the ones read at issue, execute may override them
  typedef struct packed {
    logic                         valid;
    isa_pkg::opcode_e             op;
    logic [isa_pkg::REG_AW-1:0]   rd;
    logic [isa_pkg::REG_AW-1:0]   rs1;
    logic [isa_pkg::REG_AW-1:0]   rs2;
    logic [isa_pkg::XLEN-1:0]     src_a;
    logic [isa_pkg::XLEN-1:0]     src_b;
    // Already sign-extended to XLEN
    logic [isa_pkg::XLEN-1:0]     imm;
    logic                         use_imm;
  } ex_ctrl_t;

  // Execute to result
  typedef struct packed {
    logic                         valid;
    isa_pkg::opcode_e             op;
    logic [isa_pkg::REG_AW-1:0]   rd;
    logic [isa_pkg::XLEN-1:0]     alu;
    // Low halves product
    logic [isa_pkg::XLEN-1:0]     mul_ll;
    // Sum of both cross products, only low 16 bits matter
    logic [isa_pkg::XLEN-1:0]     mul_cross;
  } rs_ctrl_t;

  // Decoder hazard state
  // MUL_WAIT while a multiply sits in execute
  typedef enum logic {
    DEC_FREE     = 1'b0,
    DEC_MUL_WAIT = 1'b1
  } dec_state_e;

endpackage

// File: source/fwd_if.sv
`timescale 1ns/100ps

// Result broadcast, used for forwarding and register writeback
interface fwd_if;

  logic                       valid;
  logic [isa_pkg::REG_AW-1:0] rd;
  logic [isa_pkg::XLEN-1:0]   data;
  // Data is the finished result
  logic                       done;
  // Set on the writeback copy, clear on the result stage copy
  logic                       src_wb;

  // Stage owning the value
  modport producer (output valid, rd, data, done, src_wb);

  // Forwarding muxes, scoreboard, register file write port
  modport consumer (input valid, rd, data, done, src_wb);

endinterface

// File: source/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [isa_pkg::REG_AW-1:0] r_addr_a_i,
  input  logic [isa_pkg::REG_AW-1:0] r_addr_b_i,
  output logic [isa_pkg::XLEN-1:0]   r_data_a_o,
  output logic [isa_pkg::XLEN-1:0]   r_data_b_o,
  fwd_if.consumer                    wb
);

  logic [isa_pkg::XLEN-1:0] regs [isa_pkg::NREG];
  logic                     wr_en;

  // Read port, r0 hard zero, same-cycle write wins
  function automatic logic [isa_pkg::XLEN-1:0] rd_port(input logic [isa_pkg::REG_AW-1:0] addr);
    if (addr == '0) return '0;
    if (wr_en && (wb.rd == addr)) return wb.data;
    return regs[addr];
  endfunction

  // Only finished writeback traffic, never r0
  assign wr_en = wb.valid && wb.done && wb.src_wb && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < isa_pkg::NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    r_data_a_o = rd_port(r_addr_a_i);
    r_data_b_o = rd_port(r_addr_b_i);
  end

endmodule

// File: source/issue_decode.sv
`timescale 1ns/100ps

module issue_decode (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [isa_pkg::XLEN-1:0]   inst_i,
  input  logic                       inst_valid_i,
  output logic                       issue_o,
  output logic [isa_pkg::REG_AW-1:0] r_addr_a_o,
  output logic [isa_pkg::REG_AW-1:0] r_addr_b_o,
  input  logic [isa_pkg::XLEN-1:0]   r_data_a_i,
  input  logic [isa_pkg::XLEN-1:0]   r_data_b_i,
  output pipe_pkg::ex_ctrl_t         ex_o,
  fwd_if.consumer                    rs_bus
);

  isa_pkg::opcode_e           opc_raw;
  isa_pkg::opcode_e           opc;
  logic [isa_pkg::REG_AW-1:0] rd;
  logic [isa_pkg::REG_AW-1:0] rs1;
  logic [isa_pkg::REG_AW-1:0] rs2;
  logic [isa_pkg::XLEN-1:0]   imm_ext;
  logic                       need_a;
  logic                       need_b;
  logic                       use_imm;
  logic                       hazard;
  logic                       issue;
  pipe_pkg::dec_state_e       state_q;
  pipe_pkg::dec_state_e       state_d;
  logic [isa_pkg::REG_AW-1:0] mul_rd_q;
  pipe_pkg::ex_ctrl_t         ex_d;
  pipe_pkg::ex_ctrl_t         ex_q;

  // Field split and sign extension
  always_comb begin
    opc_raw = isa_pkg::opcode_e'(inst_i[isa_pkg::OPC_HI:isa_pkg::OPC_LO]);
    rd      = inst_i[isa_pkg::RD_HI:isa_pkg::RD_LO];
    rs1     = inst_i[isa_pkg::RS1_HI:isa_pkg::RS1_LO];
    rs2     = inst_i[isa_pkg::RS2_HI:isa_pkg::RS2_LO];
    imm_ext = {{(isa_pkg::XLEN - isa_pkg::IMM_W){inst_i[isa_pkg::IMM_HI]}},
               inst_i[isa_pkg::IMM_HI:isa_pkg::IMM_LO]};
    opc     = opc_raw;
    need_a  = 1'b1;
    need_b  = 1'b1;
    use_imm = 1'b0;
    case (opc_raw)
      isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
      isa_pkg::OP_XOR, isa_pkg::OP_SLT, isa_pkg::OP_MUL: begin
      end
      isa_pkg::OP_ADDI: begin
        need_b  = 1'b0;
        use_imm = 1'b1;
      end
      default: begin
        // NOP and unused codes still flow down and commit to r0
        opc    = isa_pkg::OP_NOP;
        need_a = 1'b0;
        need_b = 1'b0;
        rd     = '0;
      end
    endcase
  end

  // Multiply still in execute, its product is not forwardable yet
  assign hazard = (state_q == pipe_pkg::DEC_MUL_WAIT) &&
                  ((need_a && (rs1 == mul_rd_q)) || (need_b && (rs2 == mul_rd_q)));
  assign issue   = inst_valid_i && !hazard;
  assign issue_o = issue;

  assign r_addr_a_o = rs1;
  assign r_addr_b_o = rs2;

  // Remember a multiply destination for one cycle
  assign state_d = (issue && (opc == isa_pkg::OP_MUL) && (rd != '0)) ?
                   pipe_pkg::DEC_MUL_WAIT : pipe_pkg::DEC_FREE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= pipe_pkg::DEC_FREE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_d == pipe_pkg::DEC_MUL_WAIT) begin
      mul_rd_q <= rd;
    end
  end

  // Operand capture, finished result on rs_bus picked up early
  always_comb begin
    ex_d.valid   = issue;
    ex_d.op      = opc;
    ex_d.rd      = rd;
    ex_d.rs1     = need_a ? rs1 : '0;
    ex_d.rs2     = need_b ? rs2 : '0;
    ex_d.imm     = imm_ext;
    ex_d.use_imm = use_imm;
    ex_d.src_a   = r_data_a_i;
    ex_d.src_b   = r_data_b_i;
    if (rs_bus.valid && rs_bus.done && (rs_bus.rd != '0)) begin
      if (rs_bus.rd == rs1) ex_d.src_a = rs_bus.data;
      if (rs_bus.rd == rs2) ex_d.src_b = rs_bus.data;
    end
  end

  // Bubble when nothing issues
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_q.valid <= 1'b0;
    end else begin
      ex_q <= ex_d;
    end
  end

  assign ex_o = ex_q;

endmodule

// File: source/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  pipe_pkg::ex_ctrl_t ex_i,
  fwd_if.consumer            rs_bus,
  fwd_if.consumer            wb_bus,
  output pipe_pkg::rs_ctrl_t rs_o
);

  logic [isa_pkg::XLEN-1:0] opa;
  logic [isa_pkg::XLEN-1:0] opb;
  logic [isa_pkg::XLEN-1:0] opb_alu;
  logic [isa_pkg::XLEN-1:0] alu;
  logic [15:0]              a_lo;
  logic [15:0]              a_hi;
  logic [15:0]              b_lo;
  logic [15:0]              b_hi;
  logic [isa_pkg::XLEN-1:0] mul_ll;
  logic [isa_pkg::XLEN-1:0] mul_cross;
  pipe_pkg::rs_ctrl_t       rs_d;
  pipe_pkg::rs_ctrl_t       rs_q;

  // Bus hit, r0 never forwarded
  function automatic logic bus_hit(
    input logic                       v,
    input logic                       d,
    input logic [isa_pkg::REG_AW-1:0] bus_rd,
    input logic [isa_pkg::REG_AW-1:0] src
  );
    return v && d && (src != '0) && (bus_rd == src);
  endfunction

  // Newest producer first
  function automatic logic [isa_pkg::XLEN-1:0] fwd_pick(
    input logic [isa_pkg::REG_AW-1:0] src,
    input logic [isa_pkg::XLEN-1:0]   issued
  );
    if (bus_hit(rs_bus.valid, rs_bus.done, rs_bus.rd, src)) return rs_bus.data;
    if (bus_hit(wb_bus.valid, wb_bus.done, wb_bus.rd, src)) return wb_bus.data;
    return issued;
  endfunction

  always_comb begin
    opa     = fwd_pick(ex_i.rs1, ex_i.src_a);
    opb     = fwd_pick(ex_i.rs2, ex_i.src_b);
    opb_alu = ex_i.use_imm ? ex_i.imm : opb;
    case (ex_i.op)
      isa_pkg::OP_ADD, isa_pkg::OP_ADDI: alu = opa + opb_alu;
      isa_pkg::OP_SUB: alu = opa - opb_alu;
      isa_pkg::OP_AND: alu = opa & opb_alu;
      isa_pkg::OP_OR:  alu = opa | opb_alu;
      isa_pkg::OP_XOR: alu = opa ^ opb_alu;
      isa_pkg::OP_SLT: alu = {{(isa_pkg::XLEN - 1){1'b0}}, $signed(opa) < $signed(opb_alu)};
      // NOP, and MUL which completes in result
      default:         alu = '0;
    endcase
  end

  // Multiply first half, 16-bit halves
  // High-by-high term falls outside the low 32 bits
  always_comb begin
    a_lo      = opa[15:0];
    a_hi      = opa[31:16];
    b_lo      = opb[15:0];
    b_hi      = opb[31:16];
    mul_ll    = a_lo * b_lo;
    mul_cross = a_hi * b_lo + a_lo * b_hi;
  end

  always_comb begin
    rs_d.valid     = ex_i.valid;
    rs_d.op        = ex_i.op;
    rs_d.rd        = ex_i.rd;
    rs_d.alu       = alu;
    rs_d.mul_ll    = mul_ll;
    rs_d.mul_cross = mul_cross;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rs_q.valid <= 1'b0;
    end else begin
      rs_q <= rs_d;
    end
  end

  assign rs_o = rs_q;

endmodule

// File: source/result_stage.sv
`timescale 1ns/100ps

module result_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  pipe_pkg::rs_ctrl_t         rs_i,
  fwd_if.producer                    rs_bus,
  fwd_if.producer                    wb_bus,
  output logic                       commit_valid_o,
  output logic [isa_pkg::REG_AW-1:0] commit_rd_o,
  output logic [isa_pkg::XLEN-1:0]   commit_data_o
);

  logic                       is_mul;
  logic [isa_pkg::XLEN-1:0]   mul_res;
  logic [isa_pkg::XLEN-1:0]   res;
  logic                       wb_valid_q;
  logic [isa_pkg::REG_AW-1:0] wb_rd_q;
  logic [isa_pkg::XLEN-1:0]   wb_data_q;

  assign is_mul = (rs_i.op == isa_pkg::OP_MUL);

  // Cross terms land at bit 16, overflow above bit 31 dropped
  assign mul_res = rs_i.mul_ll + {rs_i.mul_cross[15:0], 16'h0000};

  // r0 destination commits zero
  assign res = (rs_i.rd == '0) ? '0 : (is_mul ? mul_res : rs_i.alu);

  // Result register contents as seen by execute
  // Multiply shows its partial product only
  always_comb begin
    rs_bus.valid  = rs_i.valid;
    rs_bus.rd     = rs_i.rd;
    rs_bus.data   = is_mul ? rs_i.mul_ll : rs_i.alu;
    rs_bus.done   = !is_mul;
    rs_bus.src_wb = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= rs_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= rs_i.rd;
    wb_data_q <= res;
  end

  // Writeback, always final
  always_comb begin
    wb_bus.valid  = wb_valid_q;
    wb_bus.rd     = wb_rd_q;
    wb_bus.data   = wb_data_q;
    wb_bus.done   = 1'b1;
    wb_bus.src_wb = 1'b1;
  end

  // Commit trace mirrors the register file write
  assign commit_valid_o = wb_valid_q;
  assign commit_rd_o    = wb_rd_q;
  assign commit_data_o  = wb_data_q;

endmodule

// File: source/backend.sv
`timescale 1ns/100ps

module backend (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [isa_pkg::XLEN-1:0]   inst_i,
  input  logic                       inst_valid_i,
  output logic                       issue_o,
  output logic                       commit_valid_o,
  output logic [isa_pkg::REG_AW-1:0] commit_rd_o,
  output logic [isa_pkg::XLEN-1:0]   commit_data_o
);

  logic [isa_pkg::REG_AW-1:0] r_addr_a;
  logic [isa_pkg::REG_AW-1:0] r_addr_b;
  logic [isa_pkg::XLEN-1:0]   r_data_a;
  logic [isa_pkg::XLEN-1:0]   r_data_b;
  pipe_pkg::ex_ctrl_t         ex_ctrl;
  pipe_pkg::rs_ctrl_t         rs_ctrl;

  // Result register broadcast and writeback broadcast
  fwd_if rs_bus ();
  fwd_if wb_bus ();

  issue_decode issue_decode_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .issue_o      (issue_o),
    .r_addr_a_o   (r_addr_a),
    .r_addr_b_o   (r_addr_b),
    .r_data_a_i   (r_data_a),
    .r_data_b_i   (r_data_b),
    .ex_o         (ex_ctrl),
    .rs_bus       (rs_bus)
  );

  reg_file reg_file_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .r_addr_a_i (r_addr_a),
    .r_addr_b_i (r_addr_b),
    .r_data_a_o (r_data_a),
    .r_data_b_o (r_data_b),
    .wb         (wb_bus)
  );

  execute_stage execute_stage_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .ex_i   (ex_ctrl),
    .rs_bus (rs_bus),
    .wb_bus (wb_bus),
    .rs_o   (rs_ctrl)
  );

  result_stage result_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rs_i           (rs_ctrl),
    .rs_bus         (rs_bus),
    .wb_bus         (wb_bus),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

endmodule

// File: sim/backend_checker.sv
`timescale 1ns/100ps

module backend_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] inst_i,
  input  logic        inst_valid_i,
  input  logic        issue_i,
  input  logic        commit_valid_i,
  input  logic [4:0]  commit_rd_i,
  input  logic [31:0] commit_data_i,
  input  logic [4:0]  exp_rd_i,
  input  logic [31:0] exp_data_i,
  output int          mismatch_cnt_o,
  output int          other_cnt_o,
  output int          pending_o
);

  // Issue strobe to commit latency in cycles
  localparam int LATENCY = 3;

  int          cycle_cnt = 0;
  int          reset_cycles = 0;
  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int          pending = 0;
  logic        held = 1'b0;
  int          first_held = 0;
  int          last_issue = -8;
  logic        last_mul = 1'b0;
  logic [4:0]  last_mul_rd = '0;
  int          age;
  int          exp_hold;
  // Outstanding commits with the oldest at the front
  int          issue_q[$];
  logic [4:0]  rd_q[$];
  logic [31:0] data_q[$];

  assign mismatch_cnt_o = mismatch_cnt;
  assign other_cnt_o    = other_cnt;
  assign pending_o      = pending;

  task automatic flag_error(input string msg);
    other_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s expected 0x%08h got 0x%08h at %0t", name, exp, act, $time);
    end
  endtask

  // Set when the word reads register r as a source
  // r0 never counts
  function automatic logic reads_reg(input logic [31:0] word, input logic [4:0] r);
    logic [3:0] opc;
    logic       hit_a;
    logic       hit_b;
    opc   = word[isa_pkg::OPC_HI:isa_pkg::OPC_LO];
    hit_a = (r != 5'd0) && (word[isa_pkg::RS1_HI:isa_pkg::RS1_LO] == r);
    hit_b = (r != 5'd0) && (word[isa_pkg::RS2_HI:isa_pkg::RS2_LO] == r);
    case (opc)
      isa_pkg::OP_ADDI: return hit_a;
      isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
      isa_pkg::OP_XOR, isa_pkg::OP_SLT, isa_pkg::OP_MUL: return hit_a || hit_b;
      default: return 1'b0;
    endcase
  endfunction

  always @(posedge clk) begin
    cycle_cnt++;
    if (!rst_n) begin
      // First edge still sees power-up X in the pipeline
      if (reset_cycles > 0 && (issue_i !== 1'b0 || commit_valid_i !== 1'b0)) begin
        flag_error("issue_o or commit_valid_o not low during reset");
      end
      reset_cycles++;
      held     = 1'b0;
      last_mul = 1'b0;
    end else begin
      // Commit side
      if (commit_valid_i === 1'b1) begin
        if (issue_q.size() == 0) begin
          flag_error("commit_valid_o high with no instruction outstanding");
        end else begin
          age = cycle_cnt - issue_q.pop_front();
          compare_field("commit_rd_o", {27'd0, rd_q.pop_front()}, {27'd0, commit_rd_i});
          compare_field("commit_data_o", data_q.pop_front(), commit_data_i);
          if (age != LATENCY) begin
            flag_error($sformatf("commit came %0d cycles after issue, not %0d", age, LATENCY));
          end
        end
      end else if (commit_valid_i !== 1'b0) begin
        flag_error("commit_valid_o is unknown");
      end
      // Oldest entry overdue
      if (issue_q.size() > 0 && cycle_cnt - issue_q[0] > LATENCY) begin
        flag_error($sformatf("instruction issued at cycle %0d never committed", issue_q[0]));
        issue_q.delete(0);
        rd_q.delete(0);
        data_q.delete(0);
      end
      // Issue side
      if (inst_valid_i === 1'b1 && !held) begin
        held       = 1'b1;
        first_held = cycle_cnt;
      end
      if (issue_i === 1'b1) begin
        if (inst_valid_i !== 1'b1) begin
          flag_error("issue_o high without inst_valid_i");
        end else begin
          // One cycle stall for a source of the multiply issued on the edge before
          exp_hold = 0;
          if (last_mul && first_held == last_issue + 1 && reads_reg(inst_i, last_mul_rd)) begin
            exp_hold = 1;
          end
          if (cycle_cnt - first_held != exp_hold) begin
            flag_error($sformatf("instruction 0x%08h held %0d cycles before issue, expected %0d",
                                 inst_i, cycle_cnt - first_held, exp_hold));
          end
          issue_q.push_back(cycle_cnt);
          rd_q.push_back(exp_rd_i);
          data_q.push_back(exp_data_i);
          last_issue  = cycle_cnt;
          last_mul_rd = inst_i[isa_pkg::RD_HI:isa_pkg::RD_LO];
          last_mul    = (inst_i[isa_pkg::OPC_HI:isa_pkg::OPC_LO] == isa_pkg::OP_MUL) &&
                        (last_mul_rd != 5'd0);
        end
        held = 1'b0;
      end else if (issue_i !== 1'b0) begin
        flag_error("issue_o is unknown");
      end
    end
    pending = issue_q.size();
  end

endmodule

// File: sim/tb_backend.sv
`timescale 1ns/100ps

module tb_backend;

  // Three words per entry with instruction, expected rd and expected data
  localparam int MAX_ENTRIES = 64;
  // Back to back first and then with random idle gaps
  localparam int PASSES = 2;

  logic        clk;
  logic        rst_n;
  logic [31:0] inst;
  logic        inst_valid;
  logic        issue;
  logic        commit_valid;
  logic [4:0]  commit_rd;
  logic [31:0] commit_data;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  logic [31:0] stim_mem [3*MAX_ENTRIES];
  logic [31:0] rng_state;
  int          n_entries = 0;
  int          load_errors = 0;
  int          mismatch_cnt;
  int          other_cnt;
  int          pending;

  backend backend_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .inst_i         (inst),
    .inst_valid_i   (inst_valid),
    .issue_o        (issue),
    .commit_valid_o (commit_valid),
    .commit_rd_o    (commit_rd),
    .commit_data_o  (commit_data)
  );

  backend_checker backend_checker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .inst_i         (inst),
    .inst_valid_i   (inst_valid),
    .issue_i        (issue),
    .commit_valid_i (commit_valid),
    .commit_rd_i    (commit_rd),
    .commit_data_i  (commit_data),
    .exp_rd_i       (exp_rd),
    .exp_data_i     (exp_data),
    .mismatch_cnt_o (mismatch_cnt),
    .other_cnt_o    (other_cnt),
    .pending_o      (pending)
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic load_stimulus();
    $readmemh("sim/backend_stimulus.txt", stim_mem);
    // Entries run until the first word never written
    while (n_entries < MAX_ENTRIES && (^stim_mem[3*n_entries]) !== 1'bx) begin
      n_entries++;
    end
    if (n_entries == 0) begin
      load_errors++;
      $display("ERROR: no instructions read from the stimulus file");
    end
  endtask

  // Hold word and valid until issue_o seen at a rising edge
  task automatic present_inst(input logic [31:0] word, input logic [4:0] rd,
                              input logic [31:0] data);
    inst       = word;
    exp_rd     = rd;
    exp_data   = data;
    inst_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (issue !== 1'b1);
    #2;
  endtask

  task automatic run_program(input logic random_gaps);
    int gap;
    for (int i = 0; i < n_entries; i++) begin
      gap = 0;
      if (random_gaps) begin
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state % 4);
      end
      if (gap > 0) begin
        inst_valid = 1'b0;
        repeat (gap) @(posedge clk);
        #2;
      end
      present_inst(stim_mem[3*i], stim_mem[3*i+1][4:0], stim_mem[3*i+2]);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    inst       = '0;
    inst_valid = 1'b0;
    exp_rd     = '0;
    exp_data   = '0;
    rng_state  = 32'h6046;
    load_stimulus();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Idle after reset, nothing may issue or commit yet
    repeat (3) @(posedge clk);
    #2;
    run_program(1'b0);
    run_program(1'b1);
    inst_valid = 1'b0;
    // Wait for all outstanding commits
    while (pending != 0) begin
      @(posedge clk);
      #1;
    end
    // Room for a stray extra commit
    repeat (4) @(posedge clk);
    #1;
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + load_errors);
    if (mismatch_cnt + other_cnt + load_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the program length
  initial begin : watchdog
    int limit;
    #1;
    limit = PASSES * n_entries * 8 + 50;
    repeat (limit) @(posedge clk);
    $display("Timeout: run still busy after %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: sim/backend_stimulus.txt
// Columns: instruction word, expected commit rd, expected commit data (all hex)
// Every register is written before it is read, so a second pass repeats the results
70800123 01 00000123 // addi r1, r0, 0x123
71001ff0 02 fffffff0 // addi r2, r0, -16
11844000 03 00000113 // add  r3, r1, r2
220c2000 04 fffffff0 // sub  r4, r3, r1
32902000 05 00000120 // and  r5, r4, r1
43146000 06 00000133 // or   r6, r5, r3
53982000 07 00000010 // xor  r7, r6, r1
64082000 08 00000001 // slt  r8, r2, r1
64844000 09 00000000 // slt  r9, r1, r2
8504c000 0a 00015cf9 // mul  r10, r1, r6
15a8e000 0b 00015d09 // add  r11, r10, r7
76001ffe 0c fffffffe // addi r12, r0, -2
86b16000 0d fffd45ee // mul  r13, r12, r11
8735a000 0e 6f862944 // mul  r14, r13, r13
10044000 00 00000000 // add  r0, r1, r2
17802000 0f 00000123 // add  r15, r0, r1
00000000 00 00000000 // nop
2839e000 10 6f862821 // sub  r16, r14, r15

// File: build.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/fwd_if.sv
source/reg_file.sv
source/issue_decode.sv
source/execute_stage.sv
source/result_stage.sv
source/backend.sv
sim/backend_checker.sv
sim/tb_backend.sv

// File: Bender.yml
package:
  name: backend

sources:
  # Packages before their users
  - source/isa_pkg.sv
  - source/pipe_pkg.sv
  - source/fwd_if.sv
  - source/reg_file.sv
  - source/issue_decode.sv
  - source/execute_stage.sv
  - source/result_stage.sv
  - source/backend.sv
  - target: simulation
    files:
      - sim/backend_checker.sv
      - sim/tb_backend.sv
